/* verilog/simf_alu_pkg.sv */
package simf_alu_pkg;

   localparam int DATA_W = 32;

   // Instruction encodings, top byte of the control word
   localparam logic [7:0] FMT_VOP2  = 8'h01;
   localparam logic [7:0] FMT_VOP1  = 8'h02;
   localparam logic [7:0] FMT_VOPC  = 8'h04;
   localparam logic [7:0] FMT_VOP3A = 8'h08;

   localparam logic [11:0] OP_MAX_F32   = 12'h010;
   localparam logic [11:0] OP_MUL_F32   = 12'h008;
   localparam logic [11:0] OP3_MUL_F32  = 12'h108;
   localparam logic [11:0] OP3_CMP_BASE = 12'h000;   // Compares span h000 to h00F

   // F32 compare conditions, codes 7 and 8 are not implemented
   localparam logic [3:0] CMP_F   = 4'd0;
   localparam logic [3:0] CMP_LT  = 4'd1;
   localparam logic [3:0] CMP_EQ  = 4'd2;
   localparam logic [3:0] CMP_LE  = 4'd3;
   localparam logic [3:0] CMP_GT  = 4'd4;
   localparam logic [3:0] CMP_LG  = 4'd5;
   localparam logic [3:0] CMP_GE  = 4'd6;
   localparam logic [3:0] CMP_NGE = 4'd9;
   localparam logic [3:0] CMP_NLG = 4'd10;
   localparam logic [3:0] CMP_NGT = 4'd11;
   localparam logic [3:0] CMP_NLE = 4'd12;
   localparam logic [3:0] CMP_NEQ = 4'd13;
   localparam logic [3:0] CMP_NLT = 4'd14;
   localparam logic [3:0] CMP_TRU = 4'd15;

   localparam int MUL_LATENCY  = 3;
   localparam int F32_EXP_BIAS = 127;

   typedef enum logic [1:0] {SEL_ZERO, SEL_CMP, SEL_MAX, SEL_MUL} result_sel_e;

   typedef struct packed {
      logic [7:0]  fmt;
      logic [11:0] unused;
      logic [11:0] opcode;
   } alu_ctrl_op_t;

   typedef struct packed {
      logic [7:0]  fmt;
      logic [19:0] unused;
      logic [3:0]  cond;
   } alu_ctrl_cmp_t;

   // Same control word seen as an opcode or as a compare condition
   typedef union packed {
      alu_ctrl_op_t  op;
      alu_ctrl_cmp_t cmp;
   } alu_ctrl_u;

endpackage

/* verilog/alu_control_unit.sv */
`timescale 1ns/1ps

module alu_control_unit (
   input  logic                       clk,
   input  logic                       rst_n_i,
   input  logic                       start_i,
   input  simf_alu_pkg::alu_ctrl_u    control_i,
   input  logic                       exec_i,
   input  logic                       mul_valid_i,
   output logic                       mul_start_o,
   output logic [3:0]                 cmp_cond_o,
   output simf_alu_pkg::result_sel_e  result_sel_o,
   output logic                       load_o
);

   logic                       busy_q;   // Multiply in flight
   logic                       fmt_vop2;
   logic                       fmt_vopc;
   logic                       fmt_vop3a;
   logic                       is_mul;
   logic                       is_max;
   logic                       is_cmp;
   logic                       cond_ok;
   simf_alu_pkg::result_sel_e  dec_sel;

   assign fmt_vop2  = (control_i.op.fmt == simf_alu_pkg::FMT_VOP2);
   assign fmt_vopc  = (control_i.cmp.fmt == simf_alu_pkg::FMT_VOPC);
   assign fmt_vop3a = (control_i.op.fmt == simf_alu_pkg::FMT_VOP3A);

   assign is_mul = (fmt_vop2 && control_i.op.opcode == simf_alu_pkg::OP_MUL_F32) ||
                   (fmt_vop3a && control_i.op.opcode == simf_alu_pkg::OP3_MUL_F32);
   assign is_max = fmt_vop2 && (control_i.op.opcode == simf_alu_pkg::OP_MAX_F32);

   // Codes between GE and NGE have no compare behind them
   assign cond_ok = !(control_i.cmp.cond > simf_alu_pkg::CMP_GE &&
                      control_i.cmp.cond < simf_alu_pkg::CMP_NGE);

   assign is_cmp = (fmt_vopc || fmt_vop3a) && cond_ok &&
                   ((control_i.op.opcode & 12'hFF0) == simf_alu_pkg::OP3_CMP_BASE);

   always_comb
   begin
      if (!exec_i)
         dec_sel = simf_alu_pkg::SEL_ZERO;   // Lane disabled
      else if (is_mul)
         dec_sel = simf_alu_pkg::SEL_MUL;
      else if (is_max)
         dec_sel = simf_alu_pkg::SEL_MAX;
      else if (is_cmp)
         dec_sel = simf_alu_pkg::SEL_CMP;
      else
         dec_sel = simf_alu_pkg::SEL_ZERO;   // Unsupported code
   end

   // While busy, new starts are ignored and only the product can load
   assign mul_start_o  = start_i && !busy_q && (dec_sel == simf_alu_pkg::SEL_MUL);
   assign load_o       = busy_q ? mul_valid_i
                                : (start_i && dec_sel != simf_alu_pkg::SEL_MUL);
   assign result_sel_o = busy_q ? simf_alu_pkg::SEL_MUL : dec_sel;
   assign cmp_cond_o   = control_i.cmp.cond;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         busy_q <= 1'b0;
      else if (mul_start_o)
         busy_q <= 1'b1;
      else if (busy_q && mul_valid_i)
         busy_q <= 1'b0;   // Product loaded this cycle
   end

endmodule

/* verilog/alu_compare_unit.sv */
`timescale 1ns/1ps

module alu_compare_unit (
   input  logic [simf_alu_pkg::DATA_W-1:0]  src1_i,
   input  logic [simf_alu_pkg::DATA_W-1:0]  src2_i,
   input  logic [3:0]                       cond_i,
   output logic                             cmp_result_o,
   output logic [simf_alu_pkg::DATA_W-1:0]  max_data_o
);

   logic lt;
   logic eq;
   logic gt;

   // Raw bit patterns compared as unsigned integers
   assign lt = (src1_i < src2_i);
   assign eq = (src1_i == src2_i);
   assign gt = (src1_i > src2_i);

   always_comb
   begin
      case (cond_i)
         simf_alu_pkg::CMP_F   : cmp_result_o = 1'b0;
         simf_alu_pkg::CMP_LT  : cmp_result_o = lt;
         simf_alu_pkg::CMP_EQ  : cmp_result_o = eq;
         simf_alu_pkg::CMP_LE  : cmp_result_o = lt || eq;
         simf_alu_pkg::CMP_GT  : cmp_result_o = gt;
         simf_alu_pkg::CMP_LG  : cmp_result_o = !eq;
         simf_alu_pkg::CMP_GE  : cmp_result_o = !lt;
         simf_alu_pkg::CMP_NGE : cmp_result_o = lt;
         simf_alu_pkg::CMP_NLG : cmp_result_o = eq;
         simf_alu_pkg::CMP_NGT : cmp_result_o = !gt;
         simf_alu_pkg::CMP_NLE : cmp_result_o = gt;
         simf_alu_pkg::CMP_NEQ : cmp_result_o = !eq;
         simf_alu_pkg::CMP_NLT : cmp_result_o = !lt;
         simf_alu_pkg::CMP_TRU : cmp_result_o = 1'b1;
         default               : cmp_result_o = 1'b0;   // Never selected
      endcase
   end

   assign max_data_o = lt ? src2_i : src1_i;   // Ties keep src1

endmodule

/* verilog/fp_mul_unit.sv */
`timescale 1ns/1ps

module fp_mul_unit (
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         mul_start_i,
   input  logic [31:0]  opa_i,
   input  logic [31:0]  opb_i,
   output logic [31:0]  product_o,
   output logic         mul_valid_o
);

   logic [simf_alu_pkg::MUL_LATENCY-1:0]  valid_q;
   logic signed [9:0]                     exp_sum;

   logic                s1_sign_q;
   logic signed [9:0]   s1_exp_q;
   logic                s1_zero_q;
   logic [23:0]         s1_mant_a_q;
   logic [23:0]         s1_mant_b_q;

   logic                s2_sign_q;
   logic signed [9:0]   s2_exp_q;
   logic                s2_zero_q;
   logic [47:0]         s2_prod_q;

   logic signed [9:0]   norm_exp;
   logic [22:0]         norm_frac;

   // Ten bits hold the full range of the biased sum without wrapping
   assign exp_sum = $signed({2'b00, opa_i[30:23]}) + $signed({2'b00, opb_i[30:23]})
                    - $signed(10'(simf_alu_pkg::F32_EXP_BIAS));

   always_ff @(posedge clk)
   begin
      s1_sign_q   <= opa_i[31] ^ opb_i[31];
      s1_exp_q    <= exp_sum;
      s1_zero_q   <= (opa_i[30:23] == 8'd0) || (opb_i[30:23] == 8'd0);   // Denormals flush
      s1_mant_a_q <= {1'b1, opa_i[22:0]};
      s1_mant_b_q <= {1'b1, opb_i[22:0]};
   end

   always_ff @(posedge clk)
   begin
      s2_sign_q <= s1_sign_q;
      s2_exp_q  <= s1_exp_q;
      s2_zero_q <= s1_zero_q;
      s2_prod_q <= s1_mant_a_q * s1_mant_b_q;
   end

   always_comb
   begin
      if (s2_prod_q[47])
      begin
         norm_exp  = s2_exp_q + 10'sd1;   // Product in [2,4)
         norm_frac = s2_prod_q[46:24];
      end
      else
      begin
         norm_exp  = s2_exp_q;
         norm_frac = s2_prod_q[45:23];
      end
   end

   // Fraction is truncated, no rounding
   always_ff @(posedge clk)
   begin
      if (s2_zero_q || norm_exp <= 10'sd0)
         product_o <= {s2_sign_q, 31'd0};
      else if (norm_exp >= 10'sd255)
         product_o <= {s2_sign_q, 8'hFF, 23'd0};   // Signed infinity
      else
         product_o <= {s2_sign_q, norm_exp[7:0], norm_frac};
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         valid_q <= '0;
      else
         valid_q <= {valid_q[simf_alu_pkg::MUL_LATENCY-2:0], mul_start_i};
   end

   assign mul_valid_o = valid_q[simf_alu_pkg::MUL_LATENCY-1];

endmodule

/* verilog/alu_result_stage.sv */
`timescale 1ns/1ps

module alu_result_stage (
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic                             load_i,
   input  simf_alu_pkg::result_sel_e        sel_i,
   input  logic                             cmp_result_i,
   input  logic [simf_alu_pkg::DATA_W-1:0]  max_data_i,
   input  logic [simf_alu_pkg::DATA_W-1:0]  product_i,
   input  logic                             src_vcc_i,
   output logic [simf_alu_pkg::DATA_W-1:0]  vgpr_data_o,
   output logic                             vcc_o,
   output logic                             done_o
);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         vgpr_data_o <= '0;
         vcc_o       <= 1'b0;
         done_o      <= 1'b0;
      end
      else
      begin
         done_o <= load_i;   // One-cycle pulse
         if (load_i)
         begin
            case (sel_i)
               simf_alu_pkg::SEL_CMP :
               begin
                  vgpr_data_o <= '0;
                  vcc_o       <= cmp_result_i;   // Compare writes VCC only
               end
               simf_alu_pkg::SEL_MAX :
               begin
                  vgpr_data_o <= max_data_i;
                  vcc_o       <= src_vcc_i;
               end
               simf_alu_pkg::SEL_MUL :
               begin
                  vgpr_data_o <= product_i;
                  vcc_o       <= src_vcc_i;
               end
               default :
               begin
                  vgpr_data_o <= '0;
                  vcc_o       <= src_vcc_i;
               end
            endcase
         end
      end
   end

endmodule

/* verilog/simf_alu.sv */
`timescale 1ns/1ps

module simf_alu (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                alu_start_i,
   input  simf_alu_pkg::alu_ctrl_u             alu_control_i,
   input  logic [simf_alu_pkg::DATA_W-1:0]     alu_source1_data_i,
   input  logic [simf_alu_pkg::DATA_W-1:0]     alu_source2_data_i,
   input  logic                                alu_source_exec_i,
   input  logic                                alu_source_vcc_i,
   output logic [simf_alu_pkg::DATA_W-1:0]     alu_vgpr_dest_data_o,
   output logic                                alu_dest_vcc_o,
   output logic                                alu_done_o
);

   logic                             mul_start;
   logic                             mul_valid;
   logic [3:0]                       cmp_cond;
   simf_alu_pkg::result_sel_e        result_sel;
   logic                             load;
   logic                             cmp_result;
   logic [simf_alu_pkg::DATA_W-1:0]  max_data;
   logic [simf_alu_pkg::DATA_W-1:0]  product;

   alu_control_unit control_unit_inst (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .start_i      (alu_start_i),
      .control_i    (alu_control_i),
      .exec_i       (alu_source_exec_i),
      .mul_valid_i  (mul_valid),
      .mul_start_o  (mul_start),
      .cmp_cond_o   (cmp_cond),
      .result_sel_o (result_sel),
      .load_o       (load)
   );

   alu_compare_unit compare_unit_inst (
      .src1_i       (alu_source1_data_i),
      .src2_i       (alu_source2_data_i),
      .cond_i       (cmp_cond),
      .cmp_result_o (cmp_result),
      .max_data_o   (max_data)
   );

   // Sources are held stable by the issuer until done
   fp_mul_unit mul_unit_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .mul_start_i (mul_start),
      .opa_i       (alu_source1_data_i),
      .opb_i       (alu_source2_data_i),
      .product_o   (product),
      .mul_valid_o (mul_valid)
   );

   alu_result_stage result_stage_inst (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .load_i       (load),
      .sel_i        (result_sel),
      .cmp_result_i (cmp_result),
      .max_data_i   (max_data),
      .product_i    (product),
      .src_vcc_i    (alu_source_vcc_i),
      .vgpr_data_o  (alu_vgpr_dest_data_o),
      .vcc_o        (alu_dest_vcc_o),
      .done_o       (alu_done_o)
   );

endmodule

/* tests/simf_alu_sva.sv */
`timescale 1ns/1ps

module simf_alu_sva (
   input logic clk,
   input logic rst_n_i,
   input logic start_i,
   input logic mul_start_i,
   input logic done_i
);

   int assert_fail_count = 0;

   // Pipeline stages plus the result register
   a_mul_done : assert property (@(posedge clk) disable iff (!rst_n_i)
                                 mul_start_i |-> ##(simf_alu_pkg::MUL_LATENCY + 1) done_i)
      else
      begin
         $error("multiply done did not follow its start by four cycles");
         assert_fail_count++;
      end

   a_single_done : assert property (@(posedge clk) disable iff (!rst_n_i)
                                    start_i && !mul_start_i |=> done_i)
      else
      begin
         $error("single-cycle done did not follow its start by one cycle");
         assert_fail_count++;
      end

   a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n_i)
                                   done_i |=> !done_i)
      else
      begin
         $error("done stayed high for two cycles");
         assert_fail_count++;
      end

   a_reset_done : assert property (@(posedge clk) !rst_n_i |=> !done_i)
      else
      begin
         $error("done was high during reset");
         assert_fail_count++;
      end

endmodule

/* tests/simf_alu_tb.sv */
`timescale 1ns/1ps

module simf_alu_tb;

   localparam int    CLK_PERIOD = 8;
   localparam int    MAX_TESTS  = 64;
   localparam string TRACE_FILE = "tests/simf_alu_trace.txt";

   logic                     clk = 1'b0;
   logic                     rst_n_i;
   logic                     alu_start_i;
   simf_alu_pkg::alu_ctrl_u  alu_control_i;
   logic [31:0]              alu_source1_data_i;
   logic [31:0]              alu_source2_data_i;
   logic                     alu_source_exec_i;
   logic                     alu_source_vcc_i;
   logic [31:0]              alu_vgpr_dest_data_o;
   logic                     alu_dest_vcc_o;
   logic                     alu_done_o;

   int          trace_id   [MAX_TESTS];
   logic [31:0] trace_ctrl [MAX_TESTS];
   logic [31:0] trace_src1 [MAX_TESTS];
   logic [31:0] trace_src2 [MAX_TESTS];
   logic        trace_exec [MAX_TESTS];
   logic        trace_vcc  [MAX_TESTS];
   logic [31:0] trace_data [MAX_TESTS];
   logic        trace_evcc [MAX_TESTS];

   int num_tests    = 0;
   int error_count  = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int seed         = 32'h64c96dfb;

   simf_alu simf_alu_inst (
      .clk                  (clk),
      .rst_n_i              (rst_n_i),
      .alu_start_i          (alu_start_i),
      .alu_control_i        (alu_control_i),
      .alu_source1_data_i   (alu_source1_data_i),
      .alu_source2_data_i   (alu_source2_data_i),
      .alu_source_exec_i    (alu_source_exec_i),
      .alu_source_vcc_i     (alu_source_vcc_i),
      .alu_vgpr_dest_data_o (alu_vgpr_dest_data_o),
      .alu_dest_vcc_o       (alu_dest_vcc_o),
      .alu_done_o           (alu_done_o)
   );

   bind simf_alu simf_alu_sva sva_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .start_i     (alu_start_i),
      .mul_start_i (mul_start),
      .done_i      (alu_done_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      int          t_id;
      int          t_exec;
      int          t_vcc;
      int          t_evcc;
      logic [31:0] t_ctrl;
      logic [31:0] t_src1;
      logic [31:0] t_src2;
      logic [31:0] t_data;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0)
         $display("Cannot open the trace file %s", TRACE_FILE);
      else
      begin
         while (!$feof(fd) && num_tests < MAX_TESTS)
         begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %h %h %h %d %d %h %d", t_id, t_ctrl, t_src1, t_src2,
                        t_exec, t_vcc, t_data, t_evcc);
            if (n == 8)   // Comment and blank lines do not parse
            begin
               trace_id[num_tests]   = t_id;
               trace_ctrl[num_tests] = t_ctrl;
               trace_src1[num_tests] = t_src1;
               trace_src2[num_tests] = t_src2;
               trace_exec[num_tests] = t_exec[0];
               trace_vcc[num_tests]  = t_vcc[0];
               trace_data[num_tests] = t_data;
               trace_evcc[num_tests] = t_evcc[0];
               num_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic check_value(input int id, input string what,
                              input logic [31:0] actual, input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("mismatch at %0t ns: test %0d %s is %h, expected %h",
                  $time, id, what, actual, expected);
         error_count++;
      end
   endtask

   task automatic log_test_result(input int id, input int errors_before);
      if (error_count == errors_before)
      begin
         tests_passed++;
         $display("test %0d ok", id);
      end
      else
      begin
         tests_failed++;
         $display("test %0d failed", id);
      end
   endtask

   task automatic apply_reset();
      int errors_before;
      errors_before = error_count;
      repeat (4) @(posedge clk);
      rst_n_i <= 1'b1;
      @(negedge clk);
      check_value(0, "done after reset", {31'd0, alu_done_o}, 32'd0);
      check_value(0, "data after reset", alu_vgpr_dest_data_o, 32'd0);
      check_value(0, "vcc after reset", {31'd0, alu_dest_vcc_o}, 32'd0);
      log_test_result(0, errors_before);
   endtask

   task automatic run_op(input int i);
      int gap;
      int errors_before;
      gap = {$random(seed)} % 4;
      errors_before = error_count;
      repeat (gap) @(posedge clk);   // Idle cycles between operations
      @(posedge clk);
      alu_start_i        <= 1'b1;
      alu_control_i      <= trace_ctrl[i];
      alu_source1_data_i <= trace_src1[i];
      alu_source2_data_i <= trace_src2[i];
      alu_source_exec_i  <= trace_exec[i];
      alu_source_vcc_i   <= trace_vcc[i];
      @(posedge clk);
      alu_start_i <= 1'b0;   // Sources stay put until done
      do
         @(negedge clk);
      while (!alu_done_o);
      check_value(trace_id[i], "data", alu_vgpr_dest_data_o, trace_data[i]);
      check_value(trace_id[i], "vcc", {31'd0, alu_dest_vcc_o}, {31'd0, trace_evcc[i]});
      log_test_result(trace_id[i], errors_before);
   endtask

   initial
   begin
      rst_n_i            = 1'b0;
      alu_start_i        = 1'b0;
      alu_control_i      = '0;
      alu_source1_data_i = '0;
      alu_source2_data_i = '0;
      alu_source_exec_i  = 1'b0;
      alu_source_vcc_i   = 1'b0;
      load_trace();
      if (num_tests == 0)
      begin
         $display("No operations could be read from %s, nothing was tested", TRACE_FILE);
         $display("*** FAILED ***");
      end
      else
      begin
         apply_reset();
         for (int i = 0; i < num_tests; i++)
            run_op(i);
         $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                  tests_passed, tests_failed, simf_alu_inst.sva_inst.assert_fail_count);
         if (error_count == 0 && simf_alu_inst.sva_inst.assert_fail_count == 0)
            $display("*** PASSED ***");
         else
            $display("*** FAILED ***");
      end
      $finish;
   end

   // Ten cycles per operation is well above the slowest multiply with its gap
   initial
   begin
      wait (num_tests > 0);
      #((num_tests * 10 + 4) * CLK_PERIOD);
      $display("Watchdog timeout, the DUT did not finish the trace in time");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

/* tests/simf_alu_trace.txt */
# id control src1 src2 exec vcc_in expected_data expected_vcc
# control, sources and data in hex, the rest in decimal
1 04000000 40400000 40400000 1 1 00000000 0
2 04000001 3f800000 40000000 1 0 00000000 1
3 04000002 40400000 40400000 1 0 00000000 1
4 04000003 c0000000 3f800000 1 1 00000000 0
5 04000004 c0000000 3f800000 1 0 00000000 1
6 04000005 40400000 40400000 1 1 00000000 0
7 04000006 3f800000 40000000 1 1 00000000 0
8 04000009 3f800000 40000000 1 0 00000000 1
9 0400000a c0000000 3f800000 1 1 00000000 0
10 0400000b 40400000 40400000 1 0 00000000 1
11 0400000c 3f800000 40000000 1 1 00000000 0
12 0400000d 40400000 40400000 1 1 00000000 0
13 0400000e c0000000 3f800000 1 0 00000000 1
14 0400000f 3f800000 40000000 1 0 00000000 1
15 08000000 3f800000 40000000 1 1 00000000 0
16 08000001 c0000000 3f800000 1 1 00000000 0
17 08000002 3f800000 40000000 1 1 00000000 0
18 08000003 40400000 40400000 1 0 00000000 1
19 08000004 3f800000 40000000 1 1 00000000 0
20 08000005 c0000000 3f800000 1 0 00000000 1
21 08000006 40400000 40400000 1 0 00000000 1
22 08000009 c0000000 3f800000 1 1 00000000 0
23 0800000a 40400000 40400000 1 0 00000000 1
24 0800000b c0000000 3f800000 1 1 00000000 0
25 0800000c c0000000 3f800000 1 0 00000000 1
26 0800000d 3f800000 40000000 1 0 00000000 1
27 0800000e 3f800000 40000000 1 1 00000000 0
28 0800000f 40400000 40400000 1 0 00000000 1
29 01000010 3f800000 40000000 1 1 40000000 1
30 01000010 c0000000 3f800000 1 0 c0000000 0
31 01000008 40000000 40400000 1 1 40c00000 1
32 08000108 bfc00000 3fc00000 1 0 c0100000 0
33 01000008 00000123 c0000000 1 1 80000000 1
34 08000108 7f000000 7f000000 1 0 7f800000 0
35 01000008 80800000 00800000 1 1 80000000 1
36 01000008 3fc00001 3fc00001 1 0 40100001 0
37 01000008 40000000 40400000 0 1 00000000 1
38 0400000f 3f800000 40000000 0 0 00000000 0
39 01000010 3f800000 40000000 0 1 00000000 1
40 04000007 40400000 40400000 1 1 00000000 1
41 08000008 3f800000 40000000 1 1 00000000 1
42 02000001 40000000 40400000 1 1 00000000 1

/* project.f */
verilog/simf_alu_pkg.sv
verilog/alu_control_unit.sv
verilog/alu_compare_unit.sv
verilog/fp_mul_unit.sv
verilog/alu_result_stage.sv
verilog/simf_alu.sv
tests/simf_alu_sva.sv
tests/simf_alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= simf_alu_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit status
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
